/* Makefile */
# Verilator build and run for the rv_core testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* rv_core.f */
+incdir+src
src/core_types_pkg.sv
src/core_ctrl_pkg.sv
src/if_stage.sv
src/idu.sv
src/bru.sv
src/exu.sv
src/wbu.sv
src/rv_core.sv
sim/tb_rv_core.sv

/* sim/tb_rv_core.sv */
// Testbench for rv_core; runs a fixed program from an SRAM model and checks every retire in order.
`timescale 1ns/100ps
`include "core_defines.svh"
`default_nettype none

module tb_rv_core;

  import core_types_pkg::*;

  localparam int         PROG_LEN  = 33;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_REG   = 7'b0110011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  logic       i_clk;
  logic       i_rst_n;
  inst_t      i_inst_sram_rdata;
  logic       o_inst_sram_en;
  sram_addr_t o_inst_sram_addr;
  logic       o_retire_valid;
  pc_t        o_retire_pc;
  logic       o_retire_wen;
  reg_addr_t  o_retire_rd;
  xlen_t      o_retire_data;
  logic       o_retire_illegal;

  inst_t       prog [PROG_LEN];
  logic [63:0] exp_pc [32];
  logic [63:0] exp_wen [32];
  logic [63:0] exp_rd [32];
  logic [63:0] exp_data [32];
  logic [63:0] exp_ill [32];
  int          n_exp;
  int          idx;
  int          cycles;
  int          timeout_limit;

  rv_core dut (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_pc       (o_retire_pc),
    .o_retire_wen      (o_retire_wen),
    .o_retire_rd       (o_retire_rd),
    .o_retire_data     (o_retire_data),
    .o_retire_illegal  (o_retire_illegal)
  );

  always #5 i_clk = ~i_clk;

  // RV64I instruction encoders in ISA field order.
  function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Words outside the program carry an illegal opcode and a pattern folded from the address.
  function automatic inst_t sram_word(input sram_addr_t addr);
    logic [63:0] off;
    logic [31:0] fold;
    off  = addr - `RV_RESET_PC;
    fold = addr[63:32] ^ addr[31:0];
    if (addr >= `RV_RESET_PC && addr[1:0] == 2'b00 && off[63:2] < 62'(PROG_LEN)) begin
      return prog[int'(off[63:2])];
    end
    return {fold[31:7] ^ {18'b0, fold[6:0]}, 7'h7f};
  endfunction

  always @(posedge i_clk) begin
    if (o_inst_sram_en) begin
      i_inst_sram_rdata <= sram_word(o_inst_sram_addr);   // One-cycle read.
    end
  end

  task automatic load_program();
    prog[0]  = i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_IMM);
    prog[1]  = i_type(12'hffd, 5'd0, 3'b000, 5'd2, OPC_IMM);    // x2 = -3.
    prog[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);          // ADD.
    prog[3]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);          // SUB.
    prog[4]  = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);          // AND.
    prog[5]  = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);          // OR.
    prog[6]  = r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);          // XOR.
    prog[7]  = r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);          // SLT x2 < x1.
    prog[8]  = r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd9);          // SLT x1 < x2.
    prog[9]  = u_type(20'h80000, 5'd10, OPC_LUI);
    prog[10] = u_type(20'h00001, 5'd11, OPC_AUIPC);
    prog[11] = i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_IMM);       // Write to x0.
    prog[12] = r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd12);         // Reads x0.
    prog[13] = b_type(13'd8, 5'd1, 5'd1, 3'b000);                // BEQ taken.
    prog[14] = i_type(12'd99, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[15] = b_type(13'd8, 5'd1, 5'd1, 3'b001);                // BNE not taken.
    prog[16] = b_type(13'd8, 5'd2, 5'd1, 3'b001);                // BNE taken.
    prog[17] = i_type(12'd98, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[18] = b_type(13'd8, 5'd1, 5'd2, 3'b100);                // BLT taken.
    prog[19] = i_type(12'd97, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[20] = b_type(13'd8, 5'd2, 5'd1, 3'b100);                // BLT not taken.
    prog[21] = b_type(13'd8, 5'd2, 5'd1, 3'b101);                // BGE taken.
    prog[22] = i_type(12'd96, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[23] = b_type(13'd8, 5'd1, 5'd2, 3'b101);                // BGE not taken.
    prog[24] = j_type(21'd12, 5'd14);                            // JAL.
    prog[25] = i_type(12'd95, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[26] = i_type(12'd94, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[27] = i_type(12'd21, 5'd14, 3'b000, 5'd16, OPC_JALR);   // Odd target sum.
    prog[28] = i_type(12'd93, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[29] = i_type(12'd92, 5'd0, 3'b000, 5'd13, OPC_IMM);
    prog[30] = i_type(12'd3, 5'd1, 3'b001, 5'd1, OPC_IMM);       // SLLI is not supported.
    prog[31] = r_type(7'h00, 5'd14, 5'd1, 3'b000, 5'd17);
    prog[32] = j_type(21'd0, 5'd0);                              // Spin in place.
  endtask

  task automatic expect_retire(input logic [63:0] off, input logic wen, input logic [4:0] rd,
                               input logic [63:0] data, input logic ill);
    exp_pc[n_exp]   = `RV_RESET_PC + off;
    exp_wen[n_exp]  = 64'(wen);
    exp_rd[n_exp]   = 64'(rd);
    exp_data[n_exp] = data;
    exp_ill[n_exp]  = 64'(ill);
    n_exp           = n_exp + 1;
  endtask

  task automatic build_expected();
    n_exp = 0;
    expect_retire(64'h00, 1'b1, 5'd1,  64'd5, 1'b0);
    expect_retire(64'h04, 1'b1, 5'd2,  64'hffff_ffff_ffff_fffd, 1'b0);
    expect_retire(64'h08, 1'b1, 5'd3,  64'd2, 1'b0);
    expect_retire(64'h0c, 1'b1, 5'd4,  64'd8, 1'b0);
    expect_retire(64'h10, 1'b1, 5'd5,  64'd5, 1'b0);
    expect_retire(64'h14, 1'b1, 5'd6,  64'hffff_ffff_ffff_fffd, 1'b0);
    expect_retire(64'h18, 1'b1, 5'd7,  64'hffff_ffff_ffff_fff8, 1'b0);
    expect_retire(64'h1c, 1'b1, 5'd8,  64'd1, 1'b0);
    expect_retire(64'h20, 1'b1, 5'd9,  64'd0, 1'b0);
    expect_retire(64'h24, 1'b1, 5'd10, 64'hffff_ffff_8000_0000, 1'b0);
    expect_retire(64'h28, 1'b1, 5'd11, 64'h0000_0000_8000_1028, 1'b0);
    expect_retire(64'h2c, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h30, 1'b1, 5'd12, 64'd5, 1'b0);
    expect_retire(64'h34, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h3c, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h40, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h48, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h50, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h54, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h5c, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h60, 1'b1, 5'd14, 64'h0000_0000_8000_0064, 1'b0);
    expect_retire(64'h6c, 1'b1, 5'd16, 64'h0000_0000_8000_0070, 1'b0);
    expect_retire(64'h78, 1'b0, 5'd0,  64'd0, 1'b1);
    expect_retire(64'h7c, 1'b1, 5'd17, 64'h0000_0000_8000_0069, 1'b0);
    expect_retire(64'h80, 1'b0, 5'd0,  64'd0, 1'b0);
    expect_retire(64'h80, 1'b0, 5'd0,  64'd0, 1'b0);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("Timeout: retirement stalled after %0d cycles", cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  initial begin
    i_clk             = 1'b0;
    i_rst_n           = 1'b0;
    i_inst_sram_rdata = '0;
    cycles            = 0;
    idx               = 0;
    load_program();
    build_expected();
    timeout_limit = 4 * n_exp + 40;

    repeat (10) begin
      @(negedge i_clk);
      check_value("o_retire_valid", 64'(o_retire_valid), 64'd0);
      check_value("o_inst_sram_en", 64'(o_inst_sram_en), 64'd0);
    end
    @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_value("o_inst_sram_en", 64'(o_inst_sram_en), 64'd1);
    check_value("o_inst_sram_addr", o_inst_sram_addr, `RV_RESET_PC);

    while (idx < n_exp) begin
      @(negedge i_clk);
      if (idx > 0) begin
        check_value("o_retire_valid", 64'(o_retire_valid), 64'd1);   // One retire every cycle.
      end
      if (o_retire_valid) begin
        check_value("o_retire_pc", o_retire_pc, exp_pc[idx]);
        check_value("o_retire_wen", 64'(o_retire_wen), exp_wen[idx]);
        check_value("o_retire_illegal", 64'(o_retire_illegal), exp_ill[idx]);
        if (exp_wen[idx] != 64'd0) begin
          check_value("o_retire_rd", 64'(o_retire_rd), exp_rd[idx]);
          check_value("o_retire_data", o_retire_data, exp_data[idx]);
        end
        idx = idx + 1;
      end
    end

    $display("Testbench passed");
    $finish;
  end

endmodule : tb_rv_core

`default_nettype wire

/* src/bru.sv */
// Branch unit: decides taken for branches and jumps and computes the redirect target for fetch.
`timescale 1ns/100ps
`default_nettype none

module bru (
  input  logic                    i_fs_to_ds_valid,
  input  core_types_pkg::pc_t     i_pc,
  input  core_types_pkg::xlen_t   i_rs1_data,
  input  core_types_pkg::xlen_t   i_rs2_data,
  input  core_types_pkg::xlen_t   i_imm,
  input  core_ctrl_pkg::br_func_e i_br_func,
  output logic                    o_br_taken,
  output core_types_pkg::pc_t     o_br_target
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  logic cond;
  pc_t  jalr_sum;

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond = (i_rs1_data == i_rs2_data);
      BR_NE:   cond = (i_rs1_data != i_rs2_data);
      BR_LT:   cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_JAL,
      BR_JALR: cond = 1'b1;                 // Jumps always redirect.
      default: cond = 1'b0;
    endcase
  end

  assign o_br_taken = i_fs_to_ds_valid & cond;

  assign jalr_sum = i_rs1_data + i_imm;

  // JALR clears bit 0 of the sum.
  assign o_br_target = (i_br_func == BR_JALR) ? {jalr_sum[63:1], 1'b0} : i_pc + i_imm;

endmodule : bru

`default_nettype wire

/* src/core_ctrl_pkg.sv */
// Control encodings passed from decode to branch, execute, writeback and fetch control.
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_PASS_B = 4'd6    // LUI result.
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4,
    BR_JAL  = 3'd5,
    BR_JALR = 3'd6
  } br_func_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1         // AUIPC.
  } alu_a_src_e;

  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } alu_b_src_e;

  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_LINK = 1'b1       // Return address, pc plus 4.
  } wb_src_e;

  typedef enum logic {
    FS_IDLE = 1'b0,
    FS_RUN  = 1'b1
  } fetch_state_e;

endpackage : core_ctrl_pkg

`default_nettype wire

/* src/core_defines.svh */
// Core-wide constants for the RV64I core; include wherever reset PC, PC step or register count is needed.
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`default_nettype none

// Integer register file size, x0 included.
`define RV_NUM_REGS   32

// First fetch address after reset.
`define RV_RESET_PC   64'h0000_0000_8000_0000

// Sequential PC step, one 32-bit instruction.
`define RV_INST_BYTES 64'd4

`default_nettype wire

`endif

/* src/core_types_pkg.sv */
// Plain vector types for data words, PCs, instructions and register indices, shared by all stages.
`default_nettype none

package core_types_pkg;

  // Integer register and ALU data word.
  typedef logic [63:0] xlen_t;

  // Program counter.
  typedef logic [63:0] pc_t;

  // Raw 32-bit instruction word.
  typedef logic [31:0] inst_t;

  // Integer register index, x0 to x31.
  typedef logic [4:0]  reg_addr_t;

  // Byte address toward the instruction SRAM.
  typedef logic [63:0] sram_addr_t;

endpackage : core_types_pkg

`default_nettype wire

/* src/exu.sv */
// Execute unit: selects ALU operands and computes the integer result for writeback.
`timescale 1ns/100ps
`default_nettype none

module exu (
  input  core_types_pkg::pc_t       i_pc,
  input  core_types_pkg::xlen_t     i_rs1_data,
  input  core_types_pkg::xlen_t     i_rs2_data,
  input  core_types_pkg::xlen_t     i_imm,
  input  core_ctrl_pkg::alu_a_src_e i_alu_a_src,
  input  core_ctrl_pkg::alu_b_src_e i_alu_b_src,
  input  core_ctrl_pkg::alu_op_e    i_alu_op,
  output core_types_pkg::xlen_t     o_alu_result
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  logic  less;

  assign op_a = (i_alu_a_src == A_PC)  ? i_pc  : i_rs1_data;
  assign op_b = (i_alu_b_src == B_IMM) ? i_imm : i_rs2_data;

  assign less = ($signed(op_a) < $signed(op_b));   // Signed compare for SLT.

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    o_alu_result = op_a + op_b;
      ALU_SUB:    o_alu_result = op_a - op_b;
      ALU_AND:    o_alu_result = op_a & op_b;
      ALU_OR:     o_alu_result = op_a | op_b;
      ALU_XOR:    o_alu_result = op_a ^ op_b;
      ALU_SLT:    o_alu_result = {63'b0, less};
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = op_a + op_b;
    endcase
  end

endmodule : exu

`default_nettype wire

/* src/idu.sv */
// Decode unit: turns the fetched word into control, immediates and register reads; holds the register file.
`timescale 1ns/100ps
`include "core_defines.svh"
`default_nettype none

module idu (
  input  logic                     i_clk,
  input  logic                     i_fs_to_ds_valid,
  input  core_types_pkg::inst_t    i_inst,
  // register file write port from writeback
  input  logic                     i_rf_wen,
  input  core_types_pkg::reg_addr_t i_rf_waddr,
  input  core_types_pkg::xlen_t    i_rf_wdata,
  output core_types_pkg::xlen_t    o_rs1_data,
  output core_types_pkg::xlen_t    o_rs2_data,
  output core_types_pkg::xlen_t    o_imm,
  output core_ctrl_pkg::br_func_e  o_br_func,
  output core_ctrl_pkg::alu_a_src_e o_alu_a_src,
  output core_ctrl_pkg::alu_b_src_e o_alu_b_src,
  output core_ctrl_pkg::alu_op_e   o_alu_op,
  output core_types_pkg::reg_addr_t o_rd,
  output logic                     o_reg_wen,
  output core_ctrl_pkg::wb_src_e   o_wb_src,
  output logic                     o_illegal
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;
  logic       illegal;
  xlen_t      rf [`RV_NUM_REGS];

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // Sign-extended immediates.
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm       = imm_i;
    o_br_func   = BR_NONE;
    o_alu_a_src = A_RS1;
    o_alu_b_src = B_IMM;
    o_alu_op    = ALU_ADD;
    o_reg_wen   = 1'b0;
    o_wb_src    = WB_ALU;
    illegal     = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          o_reg_wen = 1'b1;                 // ADDI.
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_OP: begin
        o_alu_b_src = B_RS2;
        o_reg_wen   = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = ALU_ADD;
          10'b0100000_000: o_alu_op = ALU_SUB;
          10'b0000000_111: o_alu_op = ALU_AND;
          10'b0000000_110: o_alu_op = ALU_OR;
          10'b0000000_100: o_alu_op = ALU_XOR;
          10'b0000000_010: o_alu_op = ALU_SLT;
          default: begin
            o_reg_wen = 1'b0;
            illegal   = 1'b1;
          end
        endcase
      end
      OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_PASS_B;
        o_reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm       = imm_u;
        o_alu_a_src = A_PC;
        o_reg_wen   = 1'b1;
      end
      OPC_JAL: begin
        o_imm     = imm_j;
        o_br_func = BR_JAL;
        o_wb_src  = WB_LINK;
        o_reg_wen = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_br_func = BR_JALR;
          o_wb_src  = WB_LINK;
          o_reg_wen = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_br_func = BR_EQ;
          3'b001:  o_br_func = BR_NE;
          3'b100:  o_br_func = BR_LT;
          3'b101:  o_br_func = BR_GE;
          default: illegal   = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  assign o_illegal = i_fs_to_ds_valid & illegal;

  // Register file, two read ports and one write port.
  always_ff @(posedge i_clk) begin
    if (i_rf_wen) begin
      rf[i_rf_waddr] <= i_rf_wdata;
    end
  end

  assign o_rs1_data = (rs1 == '0) ? '0 : rf[rs1];   // x0 reads zero.
  assign o_rs2_data = (rs2 == '0) ? '0 : rf[rs2];

endmodule : idu

`default_nettype wire

/* src/if_stage.sv */
// Fetch stage: holds the PC, requests the instruction SRAM and presents each returned word to decode.
`timescale 1ns/100ps
`include "core_defines.svh"
`default_nettype none

module if_stage (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_br_taken,
  input  core_types_pkg::pc_t       i_br_target,
  // inst sram interface
  output logic                      o_inst_sram_en,
  output core_types_pkg::sram_addr_t o_inst_sram_addr,
  input  core_types_pkg::inst_t     i_inst_sram_rdata,
  // toward decode
  output logic                      o_fs_to_ds_valid,
  output core_types_pkg::pc_t       o_fs_pc,
  output core_types_pkg::inst_t     o_fs_inst
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  fetch_state_e state;
  pc_t          req_pc;     // PC of the outstanding request.
  pc_t          next_pc;

  // The next address comes straight from the current instruction, so a redirect costs no bubble.
  always_comb begin
    if (state == FS_IDLE) begin
      next_pc = `RV_RESET_PC;
    end else if (i_br_taken) begin
      next_pc = i_br_target;
    end else begin
      next_pc = req_pc + `RV_INST_BYTES;
    end
  end

  assign o_inst_sram_en   = i_rst_n;       // Fetch every cycle out of reset.
  assign o_inst_sram_addr = next_pc;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= FS_IDLE;
    end else begin
      state <= FS_RUN;                      // First request issued.
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_inst_sram_en) begin
      req_pc <= next_pc;
    end
  end

  // SRAM data arrives one cycle after the request.
  assign o_fs_to_ds_valid = (state == FS_RUN);
  assign o_fs_pc          = req_pc;
  assign o_fs_inst        = i_inst_sram_rdata;

endmodule : if_stage

`default_nettype wire

/* src/rv_core.sv */
// Top level of the single-cycle RV64I core; connect the instruction SRAM and watch the retire ports.
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  // inst sram interface
  output logic                      o_inst_sram_en,
  output core_types_pkg::sram_addr_t o_inst_sram_addr,
  input  core_types_pkg::inst_t     i_inst_sram_rdata,
  // retire report
  output logic                      o_retire_valid,
  output core_types_pkg::pc_t       o_retire_pc,
  output logic                      o_retire_wen,
  output core_types_pkg::reg_addr_t o_retire_rd,
  output core_types_pkg::xlen_t     o_retire_data,
  output logic                      o_retire_illegal
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  logic       fs_to_ds_valid;
  pc_t        fs_pc;
  inst_t      fs_inst;
  logic       br_taken;
  pc_t        br_target;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm;
  br_func_e   br_func;
  alu_a_src_e alu_a_src;
  alu_b_src_e alu_b_src;
  alu_op_e    alu_op;
  reg_addr_t  rd;
  logic       reg_wen;
  wb_src_e    wb_src;
  logic       illegal;
  xlen_t      alu_result;
  logic       rf_wen;
  reg_addr_t  rf_waddr;
  xlen_t      rf_wdata;

  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_br_taken        (br_taken),
    .i_br_target       (br_target),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_pc           (fs_pc),
    .o_fs_inst         (fs_inst)
  );

  idu u_idu (
    .i_clk            (i_clk),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_inst           (fs_inst),
    .i_rf_wen         (rf_wen),
    .i_rf_waddr       (rf_waddr),
    .i_rf_wdata       (rf_wdata),
    .o_rs1_data       (rs1_data),
    .o_rs2_data       (rs2_data),
    .o_imm            (imm),
    .o_br_func        (br_func),
    .o_alu_a_src      (alu_a_src),
    .o_alu_b_src      (alu_b_src),
    .o_alu_op         (alu_op),
    .o_rd             (rd),
    .o_reg_wen        (reg_wen),
    .o_wb_src         (wb_src),
    .o_illegal        (illegal)
  );

  bru u_bru (
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_pc             (fs_pc),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_imm            (imm),
    .i_br_func        (br_func),
    .o_br_taken       (br_taken),
    .o_br_target      (br_target)
  );

  exu u_exu (
    .i_pc         (fs_pc),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_imm        (imm),
    .i_alu_a_src  (alu_a_src),
    .i_alu_b_src  (alu_b_src),
    .i_alu_op     (alu_op),
    .o_alu_result (alu_result)
  );

  wbu u_wbu (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_pc             (fs_pc),
    .i_reg_wen        (reg_wen),
    .i_rd             (rd),
    .i_wb_src         (wb_src),
    .i_alu_result     (alu_result),
    .i_illegal        (illegal),
    .o_rf_wen         (rf_wen),
    .o_rf_waddr       (rf_waddr),
    .o_rf_wdata       (rf_wdata),
    .o_retire_valid   (o_retire_valid),
    .o_retire_pc      (o_retire_pc),
    .o_retire_wen     (o_retire_wen),
    .o_retire_rd      (o_retire_rd),
    .o_retire_data    (o_retire_data),
    .o_retire_illegal (o_retire_illegal)
  );

endmodule : rv_core

`default_nettype wire

/* src/wbu.sv */
// Writeback unit: picks the result, writes the register file and registers one retire record per instruction.
`timescale 1ns/100ps
`include "core_defines.svh"
`default_nettype none

module wbu (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_fs_to_ds_valid,
  input  core_types_pkg::pc_t       i_pc,
  input  logic                      i_reg_wen,
  input  core_types_pkg::reg_addr_t i_rd,
  input  core_ctrl_pkg::wb_src_e    i_wb_src,
  input  core_types_pkg::xlen_t     i_alu_result,
  input  logic                      i_illegal,
  // register file write port
  output logic                      o_rf_wen,
  output core_types_pkg::reg_addr_t o_rf_waddr,
  output core_types_pkg::xlen_t     o_rf_wdata,
  // retire report
  output logic                      o_retire_valid,
  output core_types_pkg::pc_t       o_retire_pc,
  output logic                      o_retire_wen,
  output core_types_pkg::reg_addr_t o_retire_rd,
  output core_types_pkg::xlen_t     o_retire_data,
  output logic                      o_retire_illegal
);

  import core_types_pkg::*;
  import core_ctrl_pkg::*;

  xlen_t wdata;

  assign wdata = (i_wb_src == WB_LINK) ? i_pc + `RV_INST_BYTES : i_alu_result;

  // x0 is never written.
  assign o_rf_wen   = i_fs_to_ds_valid & i_reg_wen & (i_rd != '0);
  assign o_rf_waddr = i_rd;
  assign o_rf_wdata = wdata;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_retire_valid   <= 1'b0;
      o_retire_wen     <= 1'b0;
      o_retire_illegal <= 1'b0;
    end else begin
      o_retire_valid   <= i_fs_to_ds_valid;
      o_retire_wen     <= o_rf_wen;
      o_retire_illegal <= i_fs_to_ds_valid & i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_retire_pc   <= i_pc;
    o_retire_rd   <= i_rd;
    o_retire_data <= wdata;
  end

endmodule : wbu

`default_nettype wire
